/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_datapath_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
verilog/core_pkg.sv
verilog/core_operand_mux.sv
verilog/core_flags.sv
verilog/core_alu.sv
verilog/core_regs.sv
verilog/core_datapath.sv
tb/core_datapath_tb.sv

/* tb/core_datapath_tb.sv */
// ============================================================
// Testbench for the register and operand datapath. Plays the
// microcode sequencer through the top-level ports and runs
// directed tests on registers, banks, extension and flags.
// ============================================================
module core_datapath_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;  // generous bound per test

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    size_e       size;
    logic        sex;
    logic        zex;
    rmux_e       rmux_sel;
    ld_e         ld_sel;
    cc_e         cc_sel;
    ral_e        ral_sel;
    opnd_e       opnd_sel;
    fetch_e      fetch_sel;
    alu_e        alu_op;
    logic        alt_swap;
    logic [31:0] din;
    logic [23:0] ea;
    logic [31:0] cr;
    logic [31:0] op0;
    logic [31:0] op1;
    logic [15:0] op2;
    logic [23:0] pc;
    logic [23:0] da;
    logic [15:0] sr;
    logic [31:0] rslt;
    logic [7:0]  cra;
    logic [31:0] crin;
    logic        cr_we;

    logic [31:0] lfsr = 32'h3d77;
    int          errors;
    int          tests_ok;
    int          tests_bad;

    core_datapath #(.NUM_BANKS(4)) dut_i (.*);

    always #10 clk = ~clk;

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 20 + 200);
        $display("watchdog expired before all tests completed");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic int field_width(input size_e sz);
        return (sz == SZ_BYTE) ? 8 : (sz == SZ_WORD) ? 16 : 32;
    endfunction

    function automatic logic [31:0] width_mask(input size_e sz);
        return (sz == SZ_LONG) ? 32'hffff_ffff : ((32'd1 << field_width(sz)) - 32'd1);
    endfunction

    function automatic int part_shift(input size_e sz, input logic [1:0] part);
        case (sz)
            SZ_BYTE: return 8 * int'(part);
            SZ_WORD: return 16 * int'(part[1]);  // upper bit picks the halfword
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] put_field(input logic [31:0] old, input logic [31:0] val,
                                              input size_e sz, input logic [1:0] part);
        logic [31:0] m;
        m = width_mask(sz) << part_shift(sz, part);
        return (old & ~m) | ((val << part_shift(sz, part)) & m);
    endfunction

    function automatic logic [31:0] get_field(input logic [31:0] word, input size_e sz,
                                              input logic [1:0] part);
        return (word >> part_shift(sz, part)) & width_mask(sz);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("%-14s ok", name);
        end else begin
            tests_bad++;
            $display("%-14s %0d mismatches", name, errors - errs_before);
        end
    endtask

    // one enabled micro-step, all selects idle unless the caller overrides them
    task automatic begin_step();
        @(posedge clk);
        cen       <= 1'b1;
        size      <= SZ_LONG;
        sex       <= 1'b0;
        zex       <= 1'b0;
        rmux_sel  <= ZERO_RMUX;
        ld_sel    <= NONE_LD;
        cc_sel    <= NONE_CC;
        ral_sel   <= NONE_RAL;
        opnd_sel  <= NONE_OPND;
        fetch_sel <= NONE_FETCH;
        alu_op    <= ALU_PASS1;
        alt_swap  <= 1'b0;
    endtask

    task automatic settle();
        begin_step();
        @(negedge clk);  // previous step has landed
    endtask

    task automatic load_md(input logic [31:0] w);
        begin_step();
        fetch_sel <= LOAD_FETCH;
        din       <= w;
    endtask

    task automatic load_operand(input logic [31:0] w, input opnd_e which);
        load_md(w);
        begin_step();
        rmux_sel <= MD_RMUX;
        opnd_sel <= which;
    endtask

    task automatic set_codes(input logic [7:0] code);
        load_md({24'd0, code});
        begin_step();
        ral_sel <= DST_RAL;
        begin_step();
        ral_sel <= SRC_RAL;
    endtask

    task automatic write_result(input ld_e target, input size_e sz, input logic [31:0] w);
        load_operand(w, LD1_OPND);
        begin_step();
        alu_op <= ALU_PASS1;
        size   <= sz;
        ld_sel <= target;
    endtask

    task automatic read_op0(input rmux_e src, input size_e sz, input logic s, input logic z);
        begin_step();
        rmux_sel <= src;
        size     <= sz;
        sex      <= s;
        zex      <= z;
        opnd_sel <= LD0_OPND;
        settle();
    endtask

    task automatic set_rfp(input logic [1:0] v);
        write_result(RFP_LD, SZ_LONG, {30'd0, v});
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        settle();
        compare("op0", 32'd0, op0);
        compare("op1", 32'd0, op1);
        compare("op2", 32'd0, {16'd0, op2});
        compare("pc", 32'd0, {8'd0, pc});
        compare("da", 32'd0, {8'd0, da});
        compare("cr_we", 32'd0, {31'd0, cr_we});
        compare("sr", 32'h0000_f800, {16'd0, sr});  // imask 7, rfp 0, flags clear
        end_test("reset_state", e0);
    endtask

    task automatic test_sized_write();
        int          e0;
        logic [7:0]  code;
        logic [31:0] model;
        logic [31:0] w;
        size_e       sz;
        logic [1:0]  part;
        string       who;
        e0 = errors;
        for (int r = 0; r < 2; r++) begin
            model = '0;
            who   = (r == 0) ? "acc" : "ptr";
            for (int k = 0; k < 3; k++) begin
                sz   = size_e'(2 - k);  // long, then word, then byte
                part = (k == 1) ? 2'd2 : 2'd1;
                code = (r == 0) ? {2'b00, 4'd2, part} : {1'b1, 3'b000, 2'd2, part};
                w    = rand_bits(32);
                set_codes(code);
                write_result(DST_LD, sz, w);
                model = put_field(model, w, sz, part);
                read_op0(SRC_RMUX, sz, 1'b0, 1'b0);
                compare({"op0 sized ", who}, get_field(model, sz, part), op0);
                read_op0(SRC_RMUX, SZ_LONG, 1'b0, 1'b0);
                compare({"op0 whole ", who}, model, op0);
            end
        end
        end_test("sized_write", e0);
    endtask

    task automatic test_banks();
        int          e0;
        logic [31:0] d0;
        logic [31:0] d2;
        e0 = errors;
        d0 = rand_bits(32);
        d2 = rand_bits(32);
        set_codes(8'h00);  // slot 0 of the current bank
        write_result(DST_LD, SZ_LONG, d0);
        set_rfp(2'd2);
        set_codes(8'h00);
        write_result(DST_LD, SZ_LONG, d2);
        read_op0(A_RMUX, SZ_LONG, 1'b0, 1'b0);
        compare("op0 A bank 2", d2, op0);
        read_op0(SRC_RMUX, SZ_LONG, 1'b0, 1'b0);
        compare("op0 src bank 2", d2, op0);
        set_rfp(2'd0);
        set_codes(8'h00);
        read_op0(A_RMUX, SZ_LONG, 1'b0, 1'b0);
        compare("op0 A bank 0", d0, op0);
        read_op0(SRC_RMUX, SZ_LONG, 1'b0, 1'b0);
        compare("op0 src bank 0", d0, op0);
        end_test("bank_isolation", e0);
    endtask

    task automatic test_extension();
        int          e0;
        logic [31:0] w;
        logic [7:0]  b;
        e0 = errors;
        w  = rand_bits(32);
        b  = w[7:0] | 8'h80;
        set_codes(8'h00);  // slot 0 of bank 0, also seen as A
        write_result(DST_LD, SZ_LONG, w);
        write_result(DST_LD, SZ_BYTE, {24'd0, b});
        read_op0(A_RMUX, SZ_BYTE, 1'b1, 1'b0);  // upper bits of A hold random data
        compare("op0 sign ext", {24'hff_ffff, b}, op0);
        read_op0(A_RMUX, SZ_BYTE, 1'b0, 1'b1);
        compare("op0 zero ext", {24'd0, b}, op0);
        end_test("extension", e0);
    endtask

    task automatic test_flags();
        int          e0;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] sum;
        logic [32:0] ssum;
        logic [4:0]  nib;
        logic        v;
        logic [7:0]  fb;
        logic [31:0] w;
        e0   = errors;
        a    = rand_bits(32);
        b    = rand_bits(32);
        sum  = {1'b0, a} + {1'b0, b};
        ssum = {a[31], a} + {b[31], b};  // signed sum one bit wider
        nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]};
        v    = ssum[32] ^ ssum[31];
        fb   = {sum[31], sum[31:0] == 32'd0, 1'b0, nib[4], 1'b0, v, 1'b0, sum[32]};
        load_operand(a, LD0_OPND);
        load_operand(b, LD1_OPND);
        begin_step();
        alu_op <= ALU_ADD;
        cc_sel <= SZHVN0C_CC;
        read_op0(F_RMUX, SZ_BYTE, 1'b0, 1'b1);
        compare("op0 flags add", {24'd0, fb}, op0);
        begin_step();
        alt_swap <= 1'b1;
        read_op0(F_RMUX, SZ_BYTE, 1'b0, 1'b1);
        compare("op0 flags alt", 32'd0, op0);
        begin_step();
        alt_swap <= 1'b1;
        read_op0(F_RMUX, SZ_BYTE, 1'b0, 1'b1);
        compare("op0 flags back", {24'd0, fb}, op0);
        w = rand_bits(8) & 32'h0000_00d7;  // bits 5 and 3 read as zero
        write_result(F_LD, SZ_LONG, w);
        read_op0(F_RMUX, SZ_BYTE, 1'b0, 1'b1);
        compare("op0 flags load", w, op0);
        end_test("flags", e0);
    endtask

    task automatic test_cr_write();
        int          e0;
        logic [31:0] x;
        logic [31:0] y;
        e0 = errors;
        x  = rand_bits(32);
        y  = rand_bits(32);
        load_operand(x, LD1_OPND);
        load_md(y);
        begin_step();
        alu_op <= ALU_PASS1;
        ld_sel <= CR_LD;
        settle();
        compare("cr_we", 32'd1, {31'd0, cr_we});
        compare("cra", {24'd0, y[7:0]}, {24'd0, cra});
        compare("crin", x, crin);
        compare("rslt", x, rslt);  // op1 passed straight through
        settle();
        compare("cr_we", 32'd0, {31'd0, cr_we});  // pulse is one cycle
        end_test("cr_write", e0);
    endtask

    initial begin
        rst       = 1'b1;
        cen       = 1'b0;
        size      = SZ_LONG;
        sex       = 1'b0;
        zex       = 1'b0;
        rmux_sel  = ZERO_RMUX;
        ld_sel    = NONE_LD;
        cc_sel    = NONE_CC;
        ral_sel   = NONE_RAL;
        opnd_sel  = NONE_OPND;
        fetch_sel = NONE_FETCH;
        alu_op    = ALU_PASS1;
        alt_swap  = 1'b0;
        din       = '0;
        ea        = 24'h00_1234;
        cr        = 32'h0000_0055;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_sized_write();
        test_banks();
        test_extension();
        test_flags();
        test_cr_write();
        $display("tests ok %0d, failing %0d, mismatches %0d", tests_ok, tests_bad, errors);
        if (tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/core_alu.sv */
// ==========================================================
// Combinational ALU working on the low 8, 16 or 32 bits of
// its operands. Returns the sized result and the raw s/z/h/v/c
// inputs consumed by the flag unit.
// ==========================================================
module core_alu import core_pkg::*; (
    input  logic [31:0] op0,
    input  logic [31:0] op1,
    input  alu_e        alu_op,
    input  size_e       size,
    output logic [31:0] rslt,
    output logic        si,
    output logic        zi,
    output logic        hi,
    output logic        vi,
    output logic        ci
);

    logic [31:0] mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] wide;
    logic [4:0]  top;
    logic        is_add;
    logic        is_sub;

    always_comb begin
        mask   = size_mask(size);
        top    = size_top(size);
        a      = op0 & mask;
        b      = op1 & mask;
        is_add = (alu_op == ALU_ADD);
        is_sub = (alu_op == ALU_SUB);
        case (alu_op)
            ALU_ADD:   wide = {1'b0, a} + {1'b0, b};
            ALU_SUB:   wide = {1'b0, a} - {1'b0, b};  // borrow fills the upper bits
            ALU_AND:   wide = {1'b0, a & b};
            ALU_OR:    wide = {1'b0, a | b};
            ALU_XOR:   wide = {1'b0, a ^ b};
            ALU_PASS1: wide = {1'b0, b};
            default:   wide = '0;
        endcase
        rslt = wide[31:0] & mask;

        si = rslt[top];
        zi = (rslt == 32'd0);
        hi = (is_add || is_sub) && (a[4] ^ b[4] ^ rslt[4]);  // carry or borrow into bit 4
        ci = (is_add || is_sub) && wide[top + 1];
        if (is_add) begin
            vi = (a[top] == b[top]) && (rslt[top] != a[top]);
        end else if (is_sub) begin
            vi = (a[top] != b[top]) && (rslt[top] != a[top]);
        end else begin
            vi = 1'b0;
        end
    end

endmodule

/* verilog/core_datapath.sv */
// ==========================================================
// Top level of the register and operand datapath. All selects
// come from the microcode sequencer each cycle; the register
// block feeds op0/op1 to the ALU and writes rslt back.
// ==========================================================
module core_datapath import core_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  size_e       size,
    input  logic        sex,
    input  logic        zex,
    input  rmux_e       rmux_sel,
    input  ld_e         ld_sel,
    input  cc_e         cc_sel,
    input  ral_e        ral_sel,
    input  opnd_e       opnd_sel,
    input  fetch_e      fetch_sel,
    input  alu_e        alu_op,
    input  logic        alt_swap,
    input  logic [31:0] din,
    input  logic [23:0] ea,
    input  logic [31:0] cr,
    output logic [31:0] op0,
    output logic [31:0] op1,
    output logic [15:0] op2,
    output logic [23:0] pc,
    output logic [23:0] da,
    output logic [15:0] sr,
    output logic [31:0] rslt,
    output logic [7:0]  cra,
    output logic [31:0] crin,
    output logic        cr_we
);

    logic si;
    logic zi;
    logic hi;
    logic vi;
    logic ci;

    core_regs #(
        .NUM_BANKS (NUM_BANKS)
    ) regs_i (
        .*
    );

    core_alu alu_i (
        .*
    );

endmodule

/* verilog/core_flags.sv */
// ==========================================================
// Flag unit. Main and alternate s/z/h/v/n/c sets, the update
// rules selected by cc_sel, the interrupt mask and the upper
// byte of the status word. Loads from F or SR beat cc rules.
// ==========================================================
module core_flags import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  cc_e         cc_sel,
    input  logic        alt_swap,
    input  logic        si,
    input  logic        zi,
    input  logic        hi,
    input  logic        vi,
    input  logic        ci,
    input  logic        f_ld,
    input  logic        sr_ld,
    input  logic        iff_ld,
    input  logic [15:0] wdata,
    input  logic [1:0]  rfp,
    output logic [7:0]  flag_byte,
    output logic [7:0]  sr_hi,
    output logic [2:0]  imask
);

    // positions inside the 6-bit flag vector
    localparam int FS = 5;
    localparam int FZ = 4;
    localparam int FH = 3;
    localparam int FV = 2;
    localparam int FN = 1;
    localparam int FC = 0;

    logic [5:0] main_f;
    logic [5:0] alt_f;
    logic [5:0] cur_f;
    logic [5:0] next_f;
    logic [5:0] load_f;

    assign load_f = {wdata[7:6], wdata[4], wdata[2:0]};  // s z . h . v n c

    always_comb begin
        cur_f  = alt_swap ? alt_f : main_f;  // cc acts on the set in use after the swap
        next_f = cur_f;
        case (cc_sel)
            SZHVN0C_CC: next_f = {si, zi, hi, vi, 1'b0, ci};
            SZHVN1C_CC: next_f = {si, zi, hi, vi, 1'b1, ci};
            N0C_CC:     next_f[FN:FC] = {1'b0, ci};
            C_CC:       next_f[FC] = ci;
            SZV_CC: begin
                next_f[FS] = si;
                next_f[FZ] = zi;
                next_f[FV] = vi;
            end
            Z2V_CC:     next_f[FV] = zi;
            default:    ;
        endcase
        if (f_ld || sr_ld) begin
            next_f = load_f;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_f <= '0;
            alt_f  <= '0;
            imask  <= 3'd7;  // all interrupts masked
        end else if (cen) begin
            main_f <= next_f;
            if (alt_swap) begin
                alt_f <= main_f;
            end
            if (sr_ld) begin
                imask <= wdata[14:12];
            end else if (iff_ld) begin
                imask <= wdata[2:0];
            end
        end
    end

    assign flag_byte = {main_f[FS], main_f[FZ], 1'b0, main_f[FH], 1'b0,
                        main_f[FV], main_f[FN], main_f[FC]};
    assign sr_hi     = {1'b1, imask, 2'b10, rfp};

endmodule

/* verilog/core_operand_mux.sv */
// ==========================================================
// Operand selector. Picks the source named by the sequencer,
// aligns sized register reads to bit 0 and applies sign or
// zero extension up to 32 bits. Purely combinational.
// ==========================================================
module core_operand_mux import core_pkg::*; (
    input  rmux_e       rmux_sel,
    input  size_e       size,
    input  logic        sex,
    input  logic        zex,
    input  reg_code_u   sd_code,
    input  logic [31:0] sd_word,
    input  logic [31:0] a_word,
    input  logic [31:0] bc_word,
    input  logic [31:0] xsp_word,
    input  logic [31:0] md,
    input  logic [23:0] pc,
    input  logic [23:0] ea,
    input  logic [31:0] cr,
    input  logic [1:0]  rfp,
    input  logic [7:0]  flag_byte,
    input  logic [7:0]  sr_hi,
    output logic [31:0] rmux
);

    logic [31:0] raw;
    logic [31:0] mask;
    logic [4:0]  sh;
    logic        msb;

    always_comb begin
        mask = size_mask(size);
        case (size)
            SZ_BYTE: sh = {sd_code.acc.part, 3'b000};
            SZ_WORD: sh = {sd_code.acc.part[1], 4'b0000};
            default: sh = 5'd0;
        endcase

        case (rmux_sel)
            A_RMUX:    raw = a_word;
            BC_RMUX:   raw = bc_word;
            CR_RMUX:   raw = cr;
            F_RMUX:    raw = {16'd0, sr_hi, flag_byte};
            PC_RMUX:   raw = {8'd0, pc};
            RFP_RMUX:  raw = {30'd0, rfp};
            XSP_RMUX:  raw = xsp_word;
            SRC_RMUX,
            DST_RMUX:  raw = (sd_word >> sh) & mask;  // selected part lands at bit 0
            N3_RMUX:   raw = {29'd0, md[2:0]};
            ZERO_RMUX: raw = 32'd0;
            ONE_RMUX:  raw = 32'd1;
            SPD_RMUX:  raw = (size == SZ_BYTE) ? 32'd1 : (size == SZ_WORD) ? 32'd2 : 32'd4;
            EA_RMUX:   raw = {8'd0, ea};
            MD_RMUX:   raw = md & mask;
            default:   raw = 32'd0;
        endcase

        // extension works above the operand size only
        msb  = raw[size_top(size)];
        rmux = raw;
        if (sex) begin
            rmux = (raw & mask) | (~mask & {32{msb}});
        end else if (zex) begin
            rmux = raw & mask;
        end
    end

    // the sequencer never asks for both extensions at once
    always_comb begin
        ext_excl: assert (!(sex && zex))
            else $error("sex and zex both high");
    end

endmodule

/* verilog/core_pkg.sv */
// ==========================================================
// Shared encodings for the register and operand datapath:
// sequencer select codes, operand size, ALU functions and the
// register-code union. Every RTL module imports this package.
// ==========================================================
package core_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE, SZ_WORD, SZ_LONG
    } size_e;

    typedef enum logic [4:0] {
        A_RMUX, BC_RMUX, CR_RMUX, F_RMUX, PC_RMUX, RFP_RMUX, XSP_RMUX,
        SRC_RMUX, DST_RMUX,
        N3_RMUX,                        // low 3 bits of md
        ZERO_RMUX, ONE_RMUX, SPD_RMUX,  // constants, spd is the step size
        EA_RMUX, MD_RMUX
    } rmux_e;

    typedef enum logic [3:0] {
        NONE_LD, DST_LD, RFP_LD, MD_LD, A_LD, BC_LD, F_LD, SR_LD,
        PC_LD, XSP_LD, IFF_LD, DA_LD, OP2_LD, CR_LD
    } ld_e;

    typedef enum logic [2:0] {
        NONE_CC, SZHVN0C_CC, SZHVN1C_CC, N0C_CC, C_CC, SZV_CC, Z2V_CC
    } cc_e;

    typedef enum logic [2:0] {
        NONE_RAL, SRC_RAL, DST_RAL, XSRC_RAL, SWP_RAL
    } ral_e;

    typedef enum logic [1:0] {
        NONE_OPND, LD0_OPND, LD1_OPND, SWP_OPND
    } opnd_e;

    typedef enum logic [1:0] {
        NONE_FETCH, LOAD_FETCH, SHIFT8_FETCH
    } fetch_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS1
    } alu_e;

    // accumulator view, idx is {bank, slot}
    typedef struct packed {
        logic       is_ptr;
        logic       spare;
        logic [3:0] idx;
        logic [1:0] part;
    } acc_code_t;

    typedef struct packed {
        logic       is_ptr;
        logic [2:0] spare;
        logic [1:0] idx;
        logic [1:0] part;
    } ptr_code_t;

    // part picks the byte, or with its upper bit the halfword
    typedef union packed {
        acc_code_t acc;
        ptr_code_t ptr;
    } reg_code_u;

    localparam logic [1:0] XSP_IDX = 2'd3;  // stack pointer
    localparam logic [1:0] BC_SLOT = 2'd1;

    function automatic logic [31:0] size_mask(input size_e sz);
        case (sz)
            SZ_BYTE: return 32'h0000_00ff;
            SZ_WORD: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // bit index of the sign bit for a given operand size
    function automatic logic [4:0] size_top(input size_e sz);
        case (sz)
            SZ_BYTE: return 5'd7;
            SZ_WORD: return 5'd15;
            default: return 5'd31;
        endcase
    endfunction

endpackage

/* verilog/core_regs.sv */
// ==========================================================
// Register block. Banked accumulators, pointer registers,
// code latches, md, pc, da and the operand latches. Sized
// write-back of rslt follows ld_sel; reads go through the
// operand mux and the flags live in the flag unit.
// ==========================================================
module core_regs import core_pkg::*; #(
    parameter int NUM_BANKS = 4  // 2 or 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  size_e       size,
    input  logic        sex,
    input  logic        zex,
    input  logic        alt_swap,
    input  rmux_e       rmux_sel,
    input  ld_e         ld_sel,
    input  cc_e         cc_sel,
    input  ral_e        ral_sel,
    input  opnd_e       opnd_sel,
    input  fetch_e      fetch_sel,
    input  logic [31:0] din,
    input  logic [23:0] ea,
    input  logic [31:0] cr,
    input  logic [31:0] rslt,
    input  logic        si,
    input  logic        zi,
    input  logic        hi,
    input  logic        vi,
    input  logic        ci,
    output logic [31:0] op0,
    output logic [31:0] op1,
    output logic [15:0] op2,
    output logic [23:0] pc,
    output logic [23:0] da,
    output logic [15:0] sr,
    output logic [7:0]  cra,
    output logic [31:0] crin,
    output logic        cr_we
);

    localparam int RFP_W  = (NUM_BANKS > 2) ? 2 : 1;
    localparam int ACC_N  = NUM_BANKS * 4;
    localparam int ACC_AW = RFP_W + 2;

    logic [31:0]       accs [ACC_N];
    logic [31:0]       ptrs [4];
    reg_code_u         src;
    reg_code_u         dst;
    reg_code_u         sd_code;
    reg_code_u         new_code;
    logic [31:0]       md;
    logic [31:0]       rmux;
    logic [31:0]       sd_word;
    logic [RFP_W-1:0]  rfp;
    logic [1:0]        rfp2;
    logic [ACC_AW-1:0] a_idx;
    logic [ACC_AW-1:0] bc_idx;
    logic [ACC_AW-1:0] sd_acc;
    logic [ACC_AW-1:0] dst_acc;
    logic [7:0]        flag_byte;
    logic [7:0]        sr_hi;

    // replace the addressed byte or halfword, or the whole word
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] val,
                                          input size_e sz, input logic [1:0] part);
        logic [31:0] res;
        res = old;
        case (sz)
            SZ_BYTE: res[{part, 3'b000} +: 8] = val[7:0];
            SZ_WORD: res[{part[1], 4'b0000} +: 16] = val[15:0];
            default: res = val;
        endcase
        return res;
    endfunction

    assign rfp2    = 2'(rfp);
    assign a_idx   = {rfp, 2'd0};
    assign bc_idx  = {rfp, BC_SLOT};
    assign sd_code = (rmux_sel == DST_RMUX) ? dst : src;
    assign sd_acc  = sd_code.acc.idx[ACC_AW-1:0];
    assign dst_acc = dst.acc.idx[ACC_AW-1:0];
    assign sd_word = sd_code.acc.is_ptr ? ptrs[sd_code.ptr.idx] : accs[sd_acc];
    assign sr      = {sr_hi, flag_byte};

    // accumulator codes from md are taken relative to the current bank
    always_comb begin
        new_code = md[7:0];
        if (!new_code.acc.is_ptr) begin
            new_code.acc.idx[3:2] = rfp2;
        end
    end

    core_operand_mux mux_i (
        .rmux_sel  (rmux_sel),
        .size      (size),
        .sex       (sex),
        .zex       (zex),
        .sd_code   (sd_code),
        .sd_word   (sd_word),
        .a_word    (accs[a_idx]),
        .bc_word   (accs[bc_idx]),
        .xsp_word  (ptrs[XSP_IDX]),
        .md        (md),
        .pc        (pc),
        .ea        (ea),
        .cr        (cr),
        .rfp       (rfp2),
        .flag_byte (flag_byte),
        .sr_hi     (sr_hi),
        .rmux      (rmux)
    );

    core_flags flags_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .cc_sel    (cc_sel),
        .alt_swap  (alt_swap),
        .si        (si),
        .zi        (zi),
        .hi        (hi),
        .vi        (vi),
        .ci        (ci),
        .f_ld      (ld_sel == F_LD),
        .sr_ld     (ld_sel == SR_LD),
        .iff_ld    (ld_sel == IFF_LD),
        .wdata     (rslt[15:0]),
        .rfp       (rfp2),
        .flag_byte (flag_byte),
        .sr_hi     (sr_hi),
        .imask     ()                   // already folded into sr_hi
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ACC_N; i++) begin
                accs[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                ptrs[i] <= '0;
            end
            src   <= '0;
            dst   <= '0;
            md    <= '0;
            pc    <= '0;
            da    <= '0;
            rfp   <= '0;
            op0   <= '0;
            op1   <= '0;
            op2   <= '0;
            cra   <= '0;
            crin  <= '0;
            cr_we <= 1'b0;
        end else if (cen) begin
            cr_we <= (ld_sel == CR_LD);  // one enabled cycle wide
            case (fetch_sel)
                LOAD_FETCH:   md <= din;
                SHIFT8_FETCH: md <= md >> 8;
                default:      ;
            endcase
            case (ral_sel)
                SRC_RAL:  src <= new_code;
                DST_RAL:  dst <= new_code;
                XSRC_RAL: src <= dst | 8'h04;  // neighbour register
                SWP_RAL: begin
                    src <= dst;
                    dst <= src;
                end
                default:  ;
            endcase
            case (opnd_sel)
                LD0_OPND: op0 <= rmux;
                LD1_OPND: op1 <= rmux;
                SWP_OPND: begin
                    op0 <= op1;
                    op1 <= op0;
                end
                default:  ;
            endcase
            case (ld_sel)
                DST_LD: begin
                    if (dst.ptr.is_ptr) begin
                        ptrs[dst.ptr.idx] <= merge(ptrs[dst.ptr.idx], rslt, size, dst.ptr.part);
                    end else begin
                        accs[dst_acc] <= merge(accs[dst_acc], rslt, size, dst.acc.part);
                    end
                end
                RFP_LD: rfp <= rslt[RFP_W-1:0];
                SR_LD:  rfp <= rslt[8 +: RFP_W];  // flags and imask load in flags_i
                MD_LD:  md  <= rslt;              // wins over a fetch
                A_LD:   accs[a_idx] <= merge(accs[a_idx], rslt, size, 2'd0);
                BC_LD:  accs[bc_idx][15:0] <= rslt[15:0];
                PC_LD:  pc  <= rslt[23:0];
                XSP_LD: ptrs[XSP_IDX] <= rslt;
                DA_LD:  da  <= rslt[23:0];
                OP2_LD: op2 <= rslt[15:0];
                CR_LD: begin
                    cra  <= md[7:0];
                    crin <= rslt;
                end
                default: ;
            endcase
        end
    end

    // a rising cr_we comes only from an enabled CR_LD and carries its data
    cr_we_pulse: assert property (@(posedge clk) disable iff (rst)
        $rose(cr_we) |-> $past(cen && ld_sel == CR_LD) && crin == $past(rslt))
        else $error("cr_we raised without a matching CR_LD write");

endmodule
